// ==== common/ooo_pkg.sv ====
package ooo_pkg;

  // Datapath widths shared by the station, the units and the CDB
  localparam int tag_width  = 6;          // Result tag, one per in-flight instruction
  localparam int data_width = 32;         // Operand and result width
  localparam int op_width   = 3;          // Opcode field width
  localparam int fu_width   = 1;          // Unit type field width

  // Operations handled by the cluster
  typedef enum logic [op_width-1:0] {
    op_add = 3'd0,                        // a + b
    op_sub = 3'd1,                        // a - b
    op_and = 3'd2,                        // Bitwise and
    op_or  = 3'd3,                        // Bitwise or
    op_xor = 3'd4,                        // Bitwise xor
    op_mul = 3'd5                         // Low half of a * b
  } op_t;

  // Unit classes a station entry can be bound to
  typedef enum logic [fu_width-1:0] {
    fu_alu  = 1'b0,                       // Single-cycle integer unit
    fu_mult = 1'b1                        // Pipelined multiplier
  } fu_type_t;

  // Which unit class executes a given opcode
  function automatic fu_type_t unit_of_op(input op_t op);
    fu_type_t unit;
    case (op)
      op_mul:  unit = fu_mult;            // Only mul goes to the multiplier
      default: unit = fu_alu;             // Everything else is integer work
    endcase
    return unit;
  endfunction

endpackage

// ==== rs/rs.sv ====
`timescale 1ns/1ps

module rs #(
  parameter int  num_alu   = 2,
  parameter int  num_mult  = 1,
  localparam int num_units = num_alu + num_mult
) (
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic                                           dispatch_valid,
  input  ooo_pkg::op_t                                   dispatch_op,
  input  logic [ooo_pkg::tag_width-1:0]                  dispatch_tag,
  input  logic [ooo_pkg::tag_width-1:0]                  src1_tag,
  input  logic                                           src1_ready,
  input  logic [ooo_pkg::data_width-1:0]                 src1_value,
  input  logic [ooo_pkg::tag_width-1:0]                  src2_tag,
  input  logic                                           src2_ready,
  input  logic [ooo_pkg::data_width-1:0]                 src2_value,
  input  logic                                           cdb_valid,
  input  logic [ooo_pkg::tag_width-1:0]                  cdb_tag,
  input  logic [ooo_pkg::data_width-1:0]                 cdb_value,
  input  logic [num_units-1:0]                           unit_ready,
  output logic                                           dispatch_stall,   // No free entry
  output logic [num_units-1:0]                           issue_valid,
  output ooo_pkg::op_t [num_units-1:0]                   issue_op,
  output logic [num_units-1:0][ooo_pkg::tag_width-1:0]   issue_tag,
  output logic [num_units-1:0][ooo_pkg::data_width-1:0]  issue_a,
  output logic [num_units-1:0][ooo_pkg::data_width-1:0]  issue_b
);

  // Entry storage, entry i is bound to unit i
  logic [num_units-1:0]                          busy;         // Entry holds an instruction
  ooo_pkg::op_t [num_units-1:0]                  e_op;         // Opcode
  logic [num_units-1:0][ooo_pkg::tag_width-1:0]  e_tag;        // Destination tag
  logic [num_units-1:0][ooo_pkg::tag_width-1:0]  e_src1_tag;   // Producer of operand 1
  logic [num_units-1:0][ooo_pkg::tag_width-1:0]  e_src2_tag;   // Producer of operand 2
  logic [num_units-1:0]                          e_src1_rdy;   // Operand 1 value valid
  logic [num_units-1:0]                          e_src2_rdy;   // Operand 2 value valid
  logic [num_units-1:0][ooo_pkg::data_width-1:0] e_src1_val;
  logic [num_units-1:0][ooo_pkg::data_width-1:0] e_src2_val;

  // Per-entry wakeup and issue terms
  logic [num_units-1:0]          wake1;         // CDB delivers operand 1 now
  logic [num_units-1:0]          wake2;         // CDB delivers operand 2 now
  logic [num_units-1:0]          entry_ready;   // Both operands available
  logic [num_units-1:0]          issuing;       // Leaves the station this cycle
  logic [num_units-1:0]          fit_free;      // Free and of the needed type
  logic [num_units-1:0]          write;         // Dispatch target, one-hot
  ooo_pkg::fu_type_t             entry_type [num_units];
  ooo_pkg::fu_type_t             need_type;     // Unit class of the dispatched op
  logic                          taken;         // First-fit search found a slot

  // Dispatch-side bypass from the CDB
  logic                          d1_wake;
  logic                          d2_wake;
  logic                          d1_rdy;
  logic                          d2_rdy;
  logic [ooo_pkg::data_width-1:0] d1_val;
  logic [ooo_pkg::data_width-1:0] d2_val;

  assign need_type = ooo_pkg::unit_of_op(dispatch_op);

  assign d1_wake = cdb_valid && !src1_ready && (src1_tag == cdb_tag);   // Produced this cycle
  assign d2_wake = cdb_valid && !src2_ready && (src2_tag == cdb_tag);
  assign d1_rdy  = src1_ready || d1_wake;
  assign d2_rdy  = src2_ready || d2_wake;
  assign d1_val  = src1_ready ? src1_value : cdb_value;
  assign d2_val  = src2_ready ? src2_value : cdb_value;

  always_comb begin
    for (int i = 0; i < num_units; i++) begin
      entry_type[i] = (i < num_alu) ? ooo_pkg::fu_alu : ooo_pkg::fu_mult;  // ALUs first
      wake1[i] = cdb_valid && !e_src1_rdy[i] && (e_src1_tag[i] == cdb_tag);  // Own tag match
      wake2[i] = cdb_valid && !e_src2_rdy[i] && (e_src2_tag[i] == cdb_tag);
      entry_ready[i] = busy[i] && (e_src1_rdy[i] || wake1[i]) && (e_src2_rdy[i] || wake2[i]);
      issuing[i]     = entry_ready[i] && unit_ready[i];   // Hold while the unit is blocked
      fit_free[i]    = (!busy[i] || issuing[i]) && (entry_type[i] == need_type);

      issue_valid[i] = issuing[i];
      issue_op[i]    = e_op[i];
      issue_tag[i]   = e_tag[i];
      issue_a[i]     = e_src1_rdy[i] ? e_src1_val[i] : cdb_value;   // Bypass on wakeup
      issue_b[i]     = e_src2_rdy[i] ? e_src2_val[i] : cdb_value;
    end
  end

  // Lowest free entry of the matching type wins
  always_comb begin
    taken = 1'b0;
    write = '0;
    for (int i = 0; i < num_units; i++) begin
      if (dispatch_valid && fit_free[i] && !taken) begin
        write[i] = 1'b1;
        taken    = 1'b1;
      end
    end
  end

  assign dispatch_stall = dispatch_valid && !(|fit_free);   // Source must retry

  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= '0;
      e_src1_rdy <= '0;
      e_src2_rdy <= '0;
    end else begin
      for (int i = 0; i < num_units; i++) begin
        if (write[i]) begin                 // New instruction overrides issue
          busy[i]       <= 1'b1;
          e_src1_rdy[i] <= d1_rdy;
          e_src2_rdy[i] <= d2_rdy;
        end else begin
          if (issuing[i])
            busy[i] <= 1'b0;
          if (wake1[i])
            e_src1_rdy[i] <= 1'b1;
          if (wake2[i])
            e_src2_rdy[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_units; i++) begin
      if (write[i]) begin
        e_op[i]       <= dispatch_op;
        e_tag[i]      <= dispatch_tag;
        e_src1_tag[i] <= src1_tag;
        e_src2_tag[i] <= src2_tag;
        e_src1_val[i] <= d1_val;
        e_src2_val[i] <= d2_val;
      end else begin
        if (wake1[i])
          e_src1_val[i] <= cdb_value;       // Capture broadcast value
        if (wake2[i])
          e_src2_val[i] <= cdb_value;
      end
    end
  end

endmodule

// ==== fu/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           issue_valid,
  input  ooo_pkg::op_t                   issue_op,
  input  logic [ooo_pkg::tag_width-1:0]  issue_tag,
  input  logic [ooo_pkg::data_width-1:0] issue_a,
  input  logic [ooo_pkg::data_width-1:0] issue_b,
  input  logic                           grant,          // CDB taken this cycle
  output logic                           unit_ready,     // Can accept an issue
  output logic                           result_valid,   // Result buffer full
  output logic [ooo_pkg::tag_width-1:0]  result_tag,
  output logic [ooo_pkg::data_width-1:0] result_value
);

  logic [ooo_pkg::data_width-1:0] alu_out;   // Combinational result
  logic                           accept;    // Issue lands in the buffer

  // Buffer frees up either empty or leaving on the CDB
  assign unit_ready = !result_valid || grant;
  assign accept     = issue_valid && unit_ready;

  always_comb begin
    case (issue_op)
      ooo_pkg::op_add: alu_out = issue_a + issue_b;
      ooo_pkg::op_sub: alu_out = issue_a - issue_b;   // Two's complement wrap
      ooo_pkg::op_and: alu_out = issue_a & issue_b;
      ooo_pkg::op_or:  alu_out = issue_a | issue_b;
      ooo_pkg::op_xor: alu_out = issue_a ^ issue_b;
      default:         alu_out = '0;                  // Mul never routed here
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (accept) begin
      result_valid <= 1'b1;          // Back-to-back refill on grant
    end else if (grant) begin
      result_valid <= 1'b0;          // Drained onto the CDB
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      result_tag   <= issue_tag;
      result_value <= alu_out;
    end
  end

endmodule

// ==== fu/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           issue_valid,
  input  ooo_pkg::op_t                   issue_op,
  input  logic [ooo_pkg::tag_width-1:0]  issue_tag,
  input  logic [ooo_pkg::data_width-1:0] issue_a,
  input  logic [ooo_pkg::data_width-1:0] issue_b,
  input  logic                           grant,          // CDB taken this cycle
  output logic                           unit_ready,     // Pipeline advances
  output logic                           result_valid,   // Result buffer full
  output logic [ooo_pkg::tag_width-1:0]  result_tag,
  output logic [ooo_pkg::data_width-1:0] result_value
);

  localparam int half_width = ooo_pkg::data_width / 2;

  // Product split into 16-bit halves, low word is ll + ((lh + hl) << half)
  logic                           advance;     // Whole pipeline moves
  logic                           is_mul;      // Only mul starts a product
  logic [ooo_pkg::data_width-1:0] p_ll_d;      // a_lo * b_lo
  logic [half_width-1:0]          cross_lh_d;  // Low half of a_lo * b_hi
  logic [half_width-1:0]          cross_d;     // Both cross terms summed

  // Stage 1 registers
  logic                           s1_valid;
  logic [ooo_pkg::tag_width-1:0]  s1_tag;
  logic [ooo_pkg::data_width-1:0] s1_ll;
  logic [half_width-1:0]          s1_cross;
  logic [half_width-1:0]          s1_a_hi;
  logic [half_width-1:0]          s1_b_lo;

  // Stage 2 registers
  logic                           s2_valid;
  logic [ooo_pkg::tag_width-1:0]  s2_tag;
  logic [ooo_pkg::data_width-1:0] s2_ll;
  logic [half_width-1:0]          s2_cross;

  assign advance    = !result_valid || grant;   // Freeze while the buffer is stuck
  assign unit_ready = advance;
  assign is_mul     = issue_op == ooo_pkg::op_mul;

  assign p_ll_d     = issue_a[half_width-1:0] * issue_b[half_width-1:0];
  assign cross_lh_d = issue_a[half_width-1:0] * issue_b[ooo_pkg::data_width-1:half_width];
  assign cross_d    = s1_cross + s1_a_hi * s1_b_lo;   // Wraps to low half

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid     <= 1'b0;
      s2_valid     <= 1'b0;
      result_valid <= 1'b0;
    end else if (advance) begin
      s1_valid     <= issue_valid && is_mul;
      s2_valid     <= s1_valid;
      result_valid <= s2_valid;          // Empty slot clears a granted buffer
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      s1_tag       <= issue_tag;
      s1_ll        <= p_ll_d;
      s1_cross     <= cross_lh_d;
      s1_a_hi      <= issue_a[ooo_pkg::data_width-1:half_width];
      s1_b_lo      <= issue_b[half_width-1:0];
      s2_tag       <= s1_tag;
      s2_ll        <= s1_ll;
      s2_cross     <= cross_d;
      result_tag   <= s2_tag;
      result_value <= s2_ll + {s2_cross, {half_width{1'b0}}};   // Final shift-add
    end
  end

endmodule

// ==== design/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter #(
  parameter int  num_alu   = 2,
  parameter int  num_mult  = 1,
  localparam int num_units = num_alu + num_mult
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [num_units-1:0]                          result_valid,
  input  logic [num_units-1:0][ooo_pkg::tag_width-1:0]  result_tag,
  input  logic [num_units-1:0][ooo_pkg::data_width-1:0] result_value,
  output logic [num_units-1:0]                          grant,       // One-hot
  output logic                                          cdb_valid,
  output logic [ooo_pkg::tag_width-1:0]                 cdb_tag,
  output logic [ooo_pkg::data_width-1:0]                cdb_value
);

  localparam int ptr_width = (num_units > 1) ? $clog2(num_units) : 1;

  logic [ptr_width-1:0] ptr;     // Highest-priority unit this cycle
  logic [ptr_width-1:0] sel;     // Granted unit
  logic                 found;   // Some unit has a result

  // Scan from the pointer and wrap around
  always_comb begin
    found = 1'b0;
    sel   = '0;
    for (int k = 0; k < num_units; k++) begin
      if (!found && result_valid[(int'(ptr) + k) % num_units]) begin
        found = 1'b1;
        sel   = ptr_width'((int'(ptr) + k) % num_units);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_units; i++) begin
      grant[i] = found && (int'(sel) == i);
    end
  end

  assign cdb_valid = found;
  assign cdb_tag   = result_tag[sel];     // Don't care when idle
  assign cdb_value = result_value[sel];

  // Winner drops to lowest priority next cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      ptr <= '0;
    end else if (found) begin
      if (int'(sel) == num_units - 1)
        ptr <= '0;
      else
        ptr <= sel + 1'b1;
    end
  end

endmodule

// ==== design/ooo_exec_top.sv ====
`timescale 1ns/1ps

module ooo_exec_top #(
  parameter int  num_alu   = 2,
  parameter int  num_mult  = 1,
  localparam int num_units = num_alu + num_mult
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_valid,
  input  ooo_pkg::op_t                   dispatch_op,
  input  logic [ooo_pkg::tag_width-1:0]  dispatch_tag,
  input  logic [ooo_pkg::tag_width-1:0]  src1_tag,
  input  logic                           src1_ready,
  input  logic [ooo_pkg::data_width-1:0] src1_value,
  input  logic [ooo_pkg::tag_width-1:0]  src2_tag,
  input  logic                           src2_ready,
  input  logic [ooo_pkg::data_width-1:0] src2_value,
  output logic                           dispatch_stall,
  output logic                           cdb_valid,
  output logic [ooo_pkg::tag_width-1:0]  cdb_tag,
  output logic [ooo_pkg::data_width-1:0] cdb_value
);

  // Station to units
  logic [num_units-1:0]                          unit_ready;
  logic [num_units-1:0]                          issue_valid;
  ooo_pkg::op_t [num_units-1:0]                  issue_op;
  logic [num_units-1:0][ooo_pkg::tag_width-1:0]  issue_tag;
  logic [num_units-1:0][ooo_pkg::data_width-1:0] issue_a;
  logic [num_units-1:0][ooo_pkg::data_width-1:0] issue_b;

  // Units to arbiter
  logic [num_units-1:0]                          result_valid;
  logic [num_units-1:0][ooo_pkg::tag_width-1:0]  result_tag;
  logic [num_units-1:0][ooo_pkg::data_width-1:0] result_value;
  logic [num_units-1:0]                          grant;

  rs #(.num_alu(num_alu), .num_mult(num_mult)) i_rs (
    .clock, .reset,
    .dispatch_valid, .dispatch_op, .dispatch_tag,
    .src1_tag, .src1_ready, .src1_value,
    .src2_tag, .src2_ready, .src2_value,
    .cdb_valid, .cdb_tag, .cdb_value,      // Wakeup feedback
    .unit_ready, .dispatch_stall,
    .issue_valid, .issue_op, .issue_tag, .issue_a, .issue_b
  );

  // Unit index matches station entry index
  for (genvar i = 0; i < num_alu; i++) begin : g_alu
    alu_unit i_alu (
      .clock, .reset,
      .issue_valid(issue_valid[i]), .issue_op(issue_op[i]), .issue_tag(issue_tag[i]),
      .issue_a(issue_a[i]), .issue_b(issue_b[i]), .grant(grant[i]),
      .unit_ready(unit_ready[i]), .result_valid(result_valid[i]),
      .result_tag(result_tag[i]), .result_value(result_value[i])
    );
  end

  for (genvar j = num_alu; j < num_units; j++) begin : g_mult
    mult_unit i_mult (
      .clock, .reset,
      .issue_valid(issue_valid[j]), .issue_op(issue_op[j]), .issue_tag(issue_tag[j]),
      .issue_a(issue_a[j]), .issue_b(issue_b[j]), .grant(grant[j]),
      .unit_ready(unit_ready[j]), .result_valid(result_valid[j]),
      .result_tag(result_tag[j]), .result_value(result_value[j])
    );
  end

  cdb_arbiter #(.num_alu(num_alu), .num_mult(num_mult)) i_arbiter (
    .clock, .reset,
    .result_valid, .result_tag, .result_value,
    .grant, .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

// ==== tb/tb_ooo_exec.sv ====
`timescale 1ns/1ps

module tb_ooo_exec;

  localparam int num_instr  = 400;                         // Instructions sent in the run
  localparam int max_cycles = num_instr * 40;              // Timeout limit
  localparam int max_stall  = 200;                         // Longest allowed stall run
  localparam int max_drain  = 200;                         // Cycles allowed to empty the cluster
  localparam int num_tags   = 1 << ooo_pkg::tag_width;
  localparam int dw         = ooo_pkg::data_width;
  localparam int tw         = ooo_pkg::tag_width;

  logic          clock;
  logic          reset;
  logic          dispatch_valid;
  ooo_pkg::op_t  dispatch_op;
  logic [tw-1:0] dispatch_tag;
  logic [tw-1:0] src1_tag;
  logic          src1_ready;
  logic [dw-1:0] src1_value;
  logic [tw-1:0] src2_tag;
  logic          src2_ready;
  logic [dw-1:0] src2_value;
  logic          dispatch_stall;
  logic          cdb_valid;
  logic [tw-1:0] cdb_tag;
  logic [dw-1:0] cdb_value;

  // Reference model state
  integer        seed = 30;
  logic          outstanding [num_tags];                  // Accepted but not yet on the CDB
  logic [dw-1:0] exp_val [num_tags];                      // Expected result per tag
  logic [tw-1:0] pool [$];                                // Free tags
  int            outstanding_count = 0;
  logic          done_now_valid;                          // Tag completing this cycle
  logic [tw-1:0] done_now_tag;
  logic          have_done = 1'b0;
  logic [dw-1:0] last_done_val;

  // Instruction being presented
  logic          held = 1'b0;
  ooo_pkg::op_t  cur_op;
  logic [tw-1:0] cur_tag;
  logic [tw-1:0] cur_src_tag [2];
  logic          cur_ready [2];
  logic [dw-1:0] cur_value [2];

  int sent = 0;
  int mul_sent = 0;
  int stall_run = 0;
  int drain_wait = 0;
  int cycle_count;
  int mismatch_count = 0;
  int other_errors = 0;

  ooo_exec_top i_dut (
    .clock, .reset,
    .dispatch_valid, .dispatch_op, .dispatch_tag,
    .src1_tag, .src1_ready, .src1_value,
    .src2_tag, .src2_ready, .src2_value,
    .dispatch_stall, .cdb_valid, .cdb_tag, .cdb_value
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Opcode rule with 32-bit wrap and the low half of the product
  function automatic logic [dw-1:0] model_result(input ooo_pkg::op_t op,
                                                 input logic [dw-1:0] a,
                                                 input logic [dw-1:0] b);
    logic [2*dw-1:0] product;
    logic [dw-1:0]   res;
    product = {{dw{1'b0}}, a} * {{dw{1'b0}}, b};
    case (op)
      ooo_pkg::op_add: res = a + b;
      ooo_pkg::op_sub: res = a - b;
      ooo_pkg::op_and: res = a & b;
      ooo_pkg::op_or:  res = a | b;
      ooo_pkg::op_xor: res = a ^ b;
      default:         res = product[dw-1:0];            // Mul
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input logic [dw-1:0] got,
                             input logic [dw-1:0] expected);
    if (got !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  // Pick one source as a ready value or a tag still in flight
  task automatic pick_source(input int s);
    logic [tw-1:0] cands [$];
    logic [31:0]   r;
    for (int t = 0; t < num_tags; t++)
      if (outstanding[t])
        cands.push_back(tw'(t));
    if (done_now_valid)
      cands.push_back(done_now_tag);                     // Exercises dispatch bypass
    r = $random(seed);
    cur_src_tag[s] = $random(seed);                      // Ignored when ready
    cur_value[s]   = $random(seed);
    cur_ready[s]   = 1'b1;
    if (cands.size() > 0 && r[0]) begin
      cur_src_tag[s] = cands[(r >> 4) % cands.size()];
      cur_ready[s]   = 1'b0;                             // Value field is junk
    end else if (have_done && r[2:1] == 2'b00) begin
      cur_value[s] = last_done_val;                      // Result of a finished tag
    end
  endtask

  task automatic build_instruction();
    logic [31:0]   r;
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    r = $random(seed);
    if ($unsigned(r) % 3 == 0) begin
      cur_op = ooo_pkg::op_mul;                          // About a third
    end else begin
      case ((r >> 8) % 5)
        0: cur_op = ooo_pkg::op_add;
        1: cur_op = ooo_pkg::op_sub;
        2: cur_op = ooo_pkg::op_and;
        3: cur_op = ooo_pkg::op_or;
        default: cur_op = ooo_pkg::op_xor;
      endcase
    end
    pick_source(0);
    pick_source(1);
    a = cur_ready[0] ? cur_value[0] : exp_val[cur_src_tag[0]];   // Producer's model value
    b = cur_ready[1] ? cur_value[1] : exp_val[cur_src_tag[1]];
    cur_tag = pool.pop_front();
    exp_val[cur_tag]     = model_result(cur_op, a, b);
    outstanding[cur_tag] = 1'b1;
    outstanding_count++;
  endtask

  // Work done at each falling edge
  task automatic run_cycle();
    done_now_valid = 1'b0;
    if (cdb_valid) begin                                 // Stable since the rising edge
      if (!outstanding[cdb_tag]) begin
        other_errors++;
        $display("Error at %0t: CDB carried tag %0d, which is not outstanding",
                 $time, cdb_tag);
      end else begin
        check_value($sformatf("cdb_value for tag %0d", cdb_tag), cdb_value, exp_val[cdb_tag]);
        outstanding[cdb_tag] = 1'b0;
        outstanding_count--;
        done_now_valid = 1'b1;
        done_now_tag   = cdb_tag;
        last_done_val  = exp_val[cdb_tag];
        have_done      = 1'b1;
      end
    end
    if (held) begin
      // Sources finished in an earlier cycle are now register values
      for (int s = 0; s < 2; s++) begin
        if (!cur_ready[s] && !outstanding[cur_src_tag[s]] &&
            !(done_now_valid && done_now_tag == cur_src_tag[s])) begin
          cur_ready[s] = 1'b1;
          cur_value[s] = exp_val[cur_src_tag[s]];
        end
      end
    end else if (sent < num_instr && pool.size() > 0 && ($random(seed) & 3) != 0) begin
      build_instruction();                               // Random idle gaps otherwise
      held = 1'b1;
    end
    dispatch_valid = held;
    dispatch_op    = cur_op;
    dispatch_tag   = cur_tag;
    src1_tag       = cur_src_tag[0];
    src1_ready     = cur_ready[0];
    src1_value     = cur_value[0];
    src2_tag       = cur_src_tag[1];
    src2_ready     = cur_ready[1];
    src2_value     = cur_value[1];
    if (done_now_valid)
      pool.push_back(done_now_tag);                      // Free from the next cycle
    #1;                                                  // Stall settles before the edge
    if (held && !dispatch_stall) begin
      held = 1'b0;
      sent++;
      if (ooo_pkg::unit_of_op(cur_op) == ooo_pkg::fu_mult)
        mul_sent++;
      stall_run = 0;
    end else if (held) begin
      stall_run++;
      if (stall_run == max_stall + 1) begin
        other_errors++;
        $display("Error at %0t: dispatch stalled for more than %0d cycles", $time, max_stall);
      end
    end else begin
      stall_run = 0;
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d instructions sent (%0d mul), %0d mismatches, %0d other errors",
             sent, mul_sent, mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  initial begin
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_op    = ooo_pkg::op_add;
    dispatch_tag   = '0;
    src1_tag       = '0;
    src1_ready     = 1'b0;
    src1_value     = '0;
    src2_tag       = '0;
    src2_ready     = 1'b0;
    src2_value     = '0;
    cur_op         = ooo_pkg::op_add;
    cur_tag        = '0;
    for (int s = 0; s < 2; s++) begin
      cur_src_tag[s] = '0;
      cur_ready[s]   = 1'b0;
      cur_value[s]   = '0;
    end
    for (int t = 0; t < num_tags; t++) begin
      outstanding[t] = 1'b0;
      exp_val[t]     = '0;
      pool.push_back(tw'(t));
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    dispatch_valid = 1'b1;                               // Probe the single mul entry
    dispatch_op    = ooo_pkg::op_mul;
    #1;
    check_value("dispatch_stall", {{(dw-1){1'b0}}, dispatch_stall}, '0);   // Station empty
    @(posedge clock);                                    // Third reset edge drops the probe
    @(negedge clock);
    reset          = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_op    = ooo_pkg::op_add;
    #1;
    check_value("cdb_valid", {{(dw-1){1'b0}}, cdb_valid}, '0);   // Quiet after reset
    while (sent < num_instr || held) begin
      @(negedge clock);
      run_cycle();
    end
    while (outstanding_count > 0 && drain_wait < max_drain) begin
      @(negedge clock);
      run_cycle();
      drain_wait++;
    end
    repeat (20) begin                                    // Catch stray CDB traffic
      @(negedge clock);
      run_cycle();
    end
    if (outstanding_count != 0) begin
      other_errors++;
      $display("Error: %0d tags still outstanding after the drain", outstanding_count);
    end
    finish_run();
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clock);
      cycle_count++;
    end
    other_errors++;
    $display("Error: run did not finish within %0d cycles, %0d tags outstanding",
             max_cycles, outstanding_count);
    finish_run();
  end

endmodule

// ==== project.f ====
common/ooo_pkg.sv
rs/rs.sv
fu/alu_unit.sv
fu/mult_unit.sv
design/cdb_arbiter.sv
design/ooo_exec_top.sv
tb/tb_ooo_exec.sv

// ==== Bender.yml ====
package:
  name: ooo_exec

sources:
  - files:
      - common/ooo_pkg.sv
      - rs/rs.sv
      - fu/alu_unit.sv
      - fu/mult_unit.sv
      - design/cdb_arbiter.sv
      - design/ooo_exec_top.sv
  - target: test
    files:
      - tb/tb_ooo_exec.sv
